// ==== verilog/mipsControl_settings.svh ====
`ifndef MIPSCONTROL_SETTINGS_SVH
`define MIPSCONTROL_SETTINGS_SVH

// instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH  6

// width of the sequencer state code
`define STATE_WIDTH  6

// primary opcodes
`define OP_RTYPE 6'd0   // funct field selects the operation
`define OP_JUMP  6'd2
`define OP_BEQ   6'd4
`define OP_BNE   6'd5
`define OP_LW    6'd35
`define OP_SW    6'd43

// funct codes handled by the controller itself
`define FUNCT_NOP   6'd0   // only bumps the pc
`define FUNCT_BREAK 6'd13  // stops the sequencer

`endif

// ==== verilog/mipsControlPkg.sv ====
`default_nettype none

`include "mipsControl_settings.svh"

package mipsControlPkg;

  typedef enum logic [`STATE_WIDTH-1:0] {
    Fetch,
    FetchWait1,
    FetchWait2,
    IrLoad,
    Decode,
    LwRegLoad,
    LwAddrCalc,
    LwMemRead,
    LwWait1,
    LwWait2,
    LwMdrLoad,
    LwWriteBack,
    SwRegLoad,
    SwAddrCalc,
    SwMemWrite,
    RRegLoad,
    RAluOp,
    RWriteBack,
    BeqRegLoad,
    BeqResolve,
    BneRegLoad,
    BneResolve,
    PcIncrement,
    Halt
  } stateType;

  typedef enum logic [3:0] {
    RType,
    Jump,
    Load,
    Store,
    BranchEq,
    BranchNe,
    Nop,
    Break,
    Unknown
  } instrClassType;

  typedef enum logic [1:0] {
    Add   = 2'd0,
    Sub   = 2'd1,
    Funct = 2'd2,  // alu control looks at funct
    Pass  = 2'd3
  } aluOpType;

  typedef enum logic [1:0] {
    RegB     = 2'd0,
    Four     = 2'd1,
    Imm      = 2'd2,  // sign extended
    ImmShift = 2'd3   // sign extended, shifted left by two
  } aluSrcBType;

  typedef enum logic [1:0] {
    AluResult  = 2'd0,
    AluOut     = 2'd1,
    JumpTarget = 2'd2
  } pcSourceType;

endpackage

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsControl_settings.svh"

module instrDecoder
  import mipsControlPkg::*;
(
  input  logic [`OPCODE_WIDTH-1:0] opCode,
  input  logic [`FUNCT_WIDTH-1:0]  funct,
  output instrClassType            instrClass
);

  instrClassType rClass;  // class within the R-type group

  always_comb begin
    case (funct)
      `FUNCT_NOP:   rClass = Nop;
      `FUNCT_BREAK: rClass = Break;
      default:      rClass = RType;
    endcase
  end

  always_comb begin
    case (opCode)
      `OP_RTYPE: instrClass = rClass;
      `OP_JUMP:  instrClass = Jump;
      `OP_LW:    instrClass = Load;
      `OP_SW:    instrClass = Store;
      `OP_BEQ:   instrClass = BranchEq;
      `OP_BNE:   instrClass = BranchNe;
      default:   instrClass = Unknown;  // treated as a pc bump only
    endcase
  end

  // an X opcode would fall into Unknown and silently skip the instruction
  always_comb begin
    assert final (!$isunknown(opCode))
      else $error("instrDecoder: opCode has unknown bits (%b)", opCode);
  end

endmodule

`default_nettype wire

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
  import mipsControlPkg::*;
(
  input  logic          Clock,
  input  logic          rst,
  input  instrClassType instrClass,
  output stateType      state
);

  stateType nextState;

  always_ff @(posedge Clock) begin
    if (rst) begin
      state <= Fetch;
    end else begin
      state <= nextState;
    end
  end

  // dispatch from Decode
  function automatic stateType decodeTarget(input instrClassType cls);
    stateType target;
    case (cls)
      RType:    target = RRegLoad;
      Jump:     target = Fetch;  // pc already written in Decode
      Load:     target = LwRegLoad;
      Store:    target = SwRegLoad;
      BranchEq: target = BeqRegLoad;
      BranchNe: target = BneRegLoad;
      Break:    target = Halt;
      default:  target = PcIncrement;  // Nop and Unknown
    endcase
    return target;
  endfunction

  always_comb begin
    case (state)
      // instruction fetch
      Fetch:       nextState = FetchWait1;
      FetchWait1:  nextState = FetchWait2;
      FetchWait2:  nextState = IrLoad;
      IrLoad:      nextState = Decode;
      Decode:      nextState = decodeTarget(instrClass);
      // load word
      LwRegLoad:   nextState = LwAddrCalc;
      LwAddrCalc:  nextState = LwMemRead;
      LwMemRead:   nextState = LwWait1;
      LwWait1:     nextState = LwWait2;
      LwWait2:     nextState = LwMdrLoad;
      LwMdrLoad:   nextState = LwWriteBack;
      LwWriteBack: nextState = PcIncrement;
      // store word
      SwRegLoad:   nextState = SwAddrCalc;
      SwAddrCalc:  nextState = SwMemWrite;
      SwMemWrite:  nextState = PcIncrement;
      // r-type
      RRegLoad:    nextState = RAluOp;
      RAluOp:      nextState = RWriteBack;
      RWriteBack:  nextState = PcIncrement;
      // branches bump the pc in the reg load state
      BeqRegLoad:  nextState = BeqResolve;
      BeqResolve:  nextState = Fetch;
      BneRegLoad:  nextState = BneResolve;
      BneResolve:  nextState = Fetch;
      PcIncrement: nextState = Fetch;
      Halt:        nextState = Halt;  // only rst gets out
      default:     nextState = Fetch;
    endcase
  end

  haltIsSticky: assert property (
    @(posedge Clock) (state == Halt && !rst) |=> (state == Halt)
  ) else $error("controlSequencer: left Halt without rst");

  decodeFollowsIrLoad: assert property (
    @(posedge Clock) (state == Decode) |-> ($past(state) == IrLoad)
  ) else $error("controlSequencer: Decode entered from %s", $past(state));

endmodule

`default_nettype wire

// ==== verilog/controlWordGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlWordGen
  import mipsControlPkg::*;
(
  input  stateType      state,
  input  instrClassType instrClass,
  output logic          pcWrite,
  output logic          pcWriteCond,
  output logic          pcWriteCondNe,
  output logic          memWrite,
  output logic          iOrD,
  output logic          irWrite,
  output logic          regWrite,
  output logic          regDst,
  output logic          memToReg,
  output logic          aluSrcA,
  output logic          regALoad,
  output logic          regBLoad,
  output logic          aluOutLoad,
  output logic          mdrLoad,
  output aluOpType      aluOp,
  output aluSrcBType    aluSrcB,
  output pcSourceType   pcSource
);

  always_comb begin
    pcWrite       = 1'b0;
    pcWriteCond   = 1'b0;
    pcWriteCondNe = 1'b0;
    memWrite      = 1'b0;
    iOrD          = 1'b0;
    irWrite       = 1'b0;
    regWrite      = 1'b0;
    regDst        = 1'b0;
    memToReg      = 1'b0;
    aluSrcA       = 1'b0;  // pc
    regALoad      = 1'b0;
    regBLoad      = 1'b0;
    aluOutLoad    = 1'b0;
    mdrLoad       = 1'b0;
    aluOp         = Add;
    aluSrcB       = RegB;
    pcSource      = AluResult;

    case (state)
      IrLoad: irWrite = 1'b1;

      Decode: begin
        case (instrClass)
          RType: regDst = 1'b1;
          Jump: begin
            pcWrite  = 1'b1;
            pcSource = JumpTarget;
          end
          BranchEq, BranchNe: begin
            aluOutLoad = 1'b1;  // branch target pc + offset
            aluSrcB    = ImmShift;
          end
          default: ;
        endcase
      end

      LwRegLoad, SwRegLoad, RRegLoad: begin
        regALoad = 1'b1;
        regBLoad = 1'b1;
      end

      LwAddrCalc, SwAddrCalc: begin
        aluSrcA    = 1'b1;  // base register
        aluSrcB    = Imm;
        aluOutLoad = 1'b1;
      end

      LwMemRead, LwWait1, LwWait2: iOrD = 1'b1;  // data address held

      LwMdrLoad: mdrLoad = 1'b1;

      LwWriteBack: begin
        regWrite = 1'b1;
        memToReg = 1'b1;
      end

      SwMemWrite: begin
        iOrD     = 1'b1;
        memWrite = 1'b1;
      end

      RAluOp: begin
        aluSrcA    = 1'b1;
        aluOp      = Funct;
        aluOutLoad = 1'b1;
      end

      RWriteBack: begin
        aluSrcA  = 1'b1;
        aluOp    = Funct;
        regWrite = 1'b1;
        regDst   = 1'b1;  // rd is the target
      end

      PcIncrement, BeqRegLoad, BneRegLoad: begin
        pcWrite  = 1'b1;
        aluSrcB  = Four;
        regALoad = (state != PcIncrement);  // operands for the compare
        regBLoad = (state != PcIncrement);
      end

      BeqResolve, BneResolve: begin
        aluSrcA       = 1'b1;
        aluOp         = Sub;  // zero flag decides
        pcSource      = AluOut;
        pcWriteCond   = (state == BeqResolve);
        pcWriteCondNe = (state == BneResolve);
      end

      default: ;  // fetch waits and Halt keep everything low
    endcase
  end

  always_comb begin
    assert final (!(memWrite && regWrite))
      else $error("controlWordGen: memWrite and regWrite together in %s", state.name());
  end

endmodule

`default_nettype wire

// ==== verilog/mipsControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsControl_settings.svh"

module mipsControl
  import mipsControlPkg::*;
(
  input  logic                     Clock,
  input  logic                     rst,
  input  logic [`OPCODE_WIDTH-1:0] opCode,
  input  logic [`FUNCT_WIDTH-1:0]  funct,
  output logic                     pcWrite,
  output logic                     pcWriteCond,
  output logic                     pcWriteCondNe,
  output logic                     memWrite,
  output logic                     iOrD,
  output logic                     irWrite,
  output logic                     regWrite,
  output logic                     regDst,
  output logic                     memToReg,
  output logic                     aluSrcA,
  output logic                     regALoad,
  output logic                     regBLoad,
  output logic                     aluOutLoad,
  output logic                     mdrLoad,
  output aluOpType                 aluOp,
  output aluSrcBType               aluSrcB,
  output pcSourceType              pcSource,
  output stateType                 state
);

  instrClassType instrClass;

  instrDecoder u_instrDecoder (
    .opCode     (opCode),
    .funct      (funct),
    .instrClass (instrClass)
  );

  controlSequencer u_controlSequencer (
    .Clock      (Clock),
    .rst        (rst),
    .instrClass (instrClass),
    .state      (state)
  );

  controlWordGen u_controlWordGen (
    .state         (state),
    .instrClass    (instrClass),
    .pcWrite       (pcWrite),
    .pcWriteCond   (pcWriteCond),
    .pcWriteCondNe (pcWriteCondNe),
    .memWrite      (memWrite),
    .iOrD          (iOrD),
    .irWrite       (irWrite),
    .regWrite      (regWrite),
    .regDst        (regDst),
    .memToReg      (memToReg),
    .aluSrcA       (aluSrcA),
    .regALoad      (regALoad),
    .regBLoad      (regBLoad),
    .aluOutLoad    (aluOutLoad),
    .mdrLoad       (mdrLoad),
    .aluOp         (aluOp),
    .aluSrcB       (aluSrcB),
    .pcSource      (pcSource)
  );

endmodule

`default_nettype wire

// ==== tests/mipsControlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsControl_settings.svh"

module mipsControlTb
  import mipsControlPkg::*;
();

  localparam int clockPeriod = 8;
  localparam int numTests = 10;
  localparam int lengthSum = 5 + 6 + 6 + 7 + 7 + 9 + 9 + 13 + 25;  // incl. break and halt wait
  localparam int watchdogCycles = lengthSum * numTests + 200;

  logic                     Clock;
  logic                     rst;
  logic [`OPCODE_WIDTH-1:0] opCode;
  logic [`FUNCT_WIDTH-1:0]  funct;
  logic pcWrite, pcWriteCond, pcWriteCondNe, memWrite, iOrD, irWrite, regWrite;
  logic regDst, memToReg, aluSrcA, regALoad, regBLoad, aluOutLoad, mdrLoad;
  aluOpType    aluOp;
  aluSrcBType  aluSrcB;
  pcSourceType pcSource;
  stateType    state;

  int          order[8];
  logic [31:0] rngState;

  mipsControl u_mipsControl (
    .Clock(Clock), .rst(rst), .opCode(opCode), .funct(funct),
    .pcWrite(pcWrite), .pcWriteCond(pcWriteCond), .pcWriteCondNe(pcWriteCondNe),
    .memWrite(memWrite), .iOrD(iOrD), .irWrite(irWrite), .regWrite(regWrite),
    .regDst(regDst), .memToReg(memToReg), .aluSrcA(aluSrcA), .regALoad(regALoad),
    .regBLoad(regBLoad), .aluOutLoad(aluOutLoad), .mdrLoad(mdrLoad),
    .aluOp(aluOp), .aluSrcB(aluSrcB), .pcSource(pcSource), .state(state)
  );

  initial Clock = 1'b0;
  always #(clockPeriod / 2) Clock = ~Clock;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic checkState(input string testName, input stateType expected,
                            input stateType actual);
    if (expected !== actual)
      abortRun($sformatf("CHECK FAILED %s: expected %s, actual %s",
                         testName, expected.name(), actual.name()));
  endtask

  task automatic checkCount(input string testName, input int expected, input int actual);
    if (expected !== actual)
      abortRun($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                         testName, expected, actual));
  endtask

  task automatic checkPcSource(input string testName, input pcSourceType expected,
                               input pcSourceType actual);
    if (expected !== actual)
      abortRun($sformatf("CHECK FAILED %s: expected %s, actual %s",
                         testName, expected.name(), actual.name()));
  endtask

  task automatic checkAluOp(input string testName, input aluOpType expected,
                            input aluOpType actual);
    if (expected !== actual)
      abortRun($sformatf("CHECK FAILED %s: expected %s, actual %s",
                         testName, expected.name(), actual.name()));
  endtask

  task automatic checkAluSrcB(input string testName, input aluSrcBType expected,
                              input aluSrcBType actual);
    if (expected !== actual)
      abortRun($sformatf("CHECK FAILED %s: expected %s, actual %s",
                         testName, expected.name(), actual.name()));
  endtask

  task automatic checkStrobesIdle(input string testName);
    int active;
    active = pcWrite + memWrite + irWrite + regWrite + pcWriteCond + pcWriteCondNe
           + mdrLoad + iOrD;
    checkCount({testName, " active strobes"}, 0, active);
  endtask

  // selects that belong to particular states of a sequence
  task automatic checkDatapathSelects(input string testName);
    checkCount({testName, " regBLoad with regALoad"}, 1, regALoad == regBLoad);
    case (state)
      LwAddrCalc, SwAddrCalc: begin
        checkCount({testName, " address aluOutLoad"}, 1, aluOutLoad);
        checkCount({testName, " address aluSrcA"}, 1, aluSrcA);  // base register
        checkAluSrcB({testName, " address aluSrcB"}, Imm, aluSrcB);
      end
      RWriteBack: checkAluOp({testName, " writeback aluOp"}, Funct, aluOp);
      BeqResolve, BneResolve: begin
        checkCount({testName, " resolve aluSrcA"}, 1, aluSrcA);
        checkAluOp({testName, " resolve aluOp"}, Sub, aluOp);
      end
      PcIncrement, BeqRegLoad, BneRegLoad: begin
        checkCount({testName, " increment aluSrcA"}, 0, aluSrcA);  // pc plus four
        checkAluSrcB({testName, " increment aluSrcB"}, Four, aluSrcB);
        checkPcSource({testName, " increment pcSource"}, AluResult, pcSource);
      end
      default: ;
    endcase
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic waitForState(input stateType target);
    while (state !== target) @(negedge Clock);
  endtask

  task automatic applyReset(input string testName);
    @(posedge Clock);
    rst <= 1'b1;
    repeat (4) begin
      @(posedge Clock);
      @(negedge Clock);
      checkState({testName, " in reset"}, Fetch, state);
      checkStrobesIdle({testName, " in reset"});
    end
    @(posedge Clock);
    rst <= 1'b0;
    @(negedge Clock);
  endtask

  // runs one instruction from Fetch to the next Fetch and counts strobes
  task automatic runInstruction(input string testName, input logic [5:0] op,
                                input logic [5:0] fn, input int expLen, input int expRegWrite,
                                input int expMdrLoad, input int expIOrD, input int expMemWrite,
                                input int expCond, input int expCondNe, input int expRegLoad,
                                input int expRegDst, input int expMemToReg);
    int cycles, nIr, nPc, nReg, nMdr, nIOrD, nMem, nCond, nCondNe;
    int nRegLoad, nRegDst, nMemToReg;
    logic jumpDecode;
    cycles = 0;
    nIr = 0;
    nPc = 0;
    nReg = 0;
    nMdr = 0;
    nIOrD = 0;
    nMem = 0;
    nCond = 0;
    nCondNe = 0;
    nRegLoad = 0;
    nRegDst = 0;
    nMemToReg = 0;
    jumpDecode = 1'b0;
    waitForState(Fetch);
    do begin
      if (state == Decode && op == `OP_JUMP) begin
        checkCount({testName, " decode pcWrite"}, 1, pcWrite);
        checkPcSource({testName, " decode pcSource"}, JumpTarget, pcSource);
        jumpDecode = 1'b1;
      end
      if (state == Decode && (op == `OP_BEQ || op == `OP_BNE)) begin
        checkCount({testName, " decode aluOutLoad"}, 1, aluOutLoad);
        checkAluSrcB({testName, " decode aluSrcB"}, ImmShift, aluSrcB);
      end
      checkDatapathSelects(testName);
      if (memWrite && regWrite)
        abortRun($sformatf("%s: memWrite and regWrite were high together in %s",
                           testName, state.name()));
      if (pcWriteCond || pcWriteCondNe)
        checkPcSource({testName, " branch pcSource"}, AluOut, pcSource);
      nIr += irWrite;
      nPc += pcWrite;
      nReg += regWrite;
      nMdr += mdrLoad;
      nIOrD += iOrD;
      nMem += memWrite;
      nCond += pcWriteCond;
      nCondNe += pcWriteCondNe;
      nRegLoad += regALoad;
      nRegDst += regDst;
      nMemToReg += memToReg;
      cycles++;
      @(posedge Clock);
      if (cycles == 1) begin
        opCode <= op;  // stable long before IrLoad
        funct <= fn;
      end
      @(negedge Clock);
      if (jumpDecode) begin
        checkState({testName, " after decode"}, Fetch, state);
        jumpDecode = 1'b0;
      end
    end while (state != Fetch);
    checkCount({testName, " cycles"}, expLen, cycles);
    checkCount({testName, " irWrite"}, 1, nIr);
    checkCount({testName, " pcWrite"}, 1, nPc);
    checkCount({testName, " regWrite"}, expRegWrite, nReg);
    checkCount({testName, " mdrLoad"}, expMdrLoad, nMdr);
    checkCount({testName, " iOrD"}, expIOrD, nIOrD);
    checkCount({testName, " memWrite"}, expMemWrite, nMem);
    checkCount({testName, " pcWriteCond"}, expCond, nCond);
    checkCount({testName, " pcWriteCondNe"}, expCondNe, nCondNe);
    checkCount({testName, " regALoad"}, expRegLoad, nRegLoad);
    checkCount({testName, " regDst"}, expRegDst, nRegDst);
    checkCount({testName, " memToReg"}, expMemToReg, nMemToReg);
  endtask

  task automatic runTest(input int idx);
    case (idx)
      0: runInstruction("rtype", `OP_RTYPE, 6'd32, 9, 1, 0, 0, 0, 0, 0, 1, 2, 0);
      1: runInstruction("jump", `OP_JUMP, 6'd0, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      2: runInstruction("load", `OP_LW, 6'd0, 13, 1, 1, 3, 0, 0, 0, 1, 0, 1);
      3: runInstruction("store", `OP_SW, 6'd0, 9, 0, 0, 1, 1, 0, 0, 1, 0, 0);
      4: runInstruction("beq", `OP_BEQ, 6'd0, 7, 0, 0, 0, 0, 1, 0, 1, 0, 0);
      5: runInstruction("bne", `OP_BNE, 6'd0, 7, 0, 0, 0, 0, 0, 1, 1, 0, 0);
      6: runInstruction("nop", `OP_RTYPE, `FUNCT_NOP, 6, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      default: runInstruction("unknown", 6'd8, 6'd0, 6, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endcase
  endtask

  task automatic resetMidInstruction();
    waitForState(Fetch);
    @(posedge Clock);
    opCode <= `OP_LW;
    funct <= 6'd0;
    @(negedge Clock);
    waitForState(LwMemRead);
    applyReset("mid reset");
    checkState("mid reset", Fetch, state);
    checkStrobesIdle("mid reset");
  endtask

  task automatic breakHalts();
    int cycles;
    cycles = 0;
    waitForState(Fetch);
    @(posedge Clock);
    opCode <= `OP_RTYPE;
    funct <= `FUNCT_BREAK;
    @(negedge Clock);
    cycles = 1;
    while (state != Halt) begin
      @(negedge Clock);
      cycles++;
    end
    checkCount("break cycles to halt", 5, cycles);  // five states, then Halt
    repeat (20) begin
      @(negedge Clock);
      checkState("break halt", Halt, state);
      checkStrobesIdle("break halt");
    end
    applyReset("break reset");
    checkState("break reset", Fetch, state);
  endtask

  initial begin
    #(watchdogCycles * clockPeriod);
    abortRun("watchdog: the tests did not finish in the expected time");
  end

  initial begin
    int i, j, tmp;
    rst <= 1'b1;
    opCode <= 6'd0;
    funct <= 6'd0;
    for (i = 0; i < 8; i++) order[i] = i;
    rngState = 32'hcd0c;
    for (i = 7; i > 0; i--) begin  // shuffle the test order
      rngState = lcgNext(rngState);
      j = (rngState >> 16) % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    repeat (5) @(posedge Clock);
    rst <= 1'b0;
    @(negedge Clock);
    checkState("after reset", Fetch, state);
    checkStrobesIdle("after reset");
    for (i = 0; i < 8; i++) runTest(order[i]);
    resetMidInstruction();
    breakHalts();  // last, leaves the sequencer in Fetch after rst
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/mipsControlPkg.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/controlWordGen.sv
verilog/mipsControl.sv
tests/mipsControlTb.sv

// ==== Bender.yml ====
package:
  name: mips_control

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mipsControlPkg.sv
      - verilog/instrDecoder.sv
      - verilog/controlSequencer.sv
      - verilog/controlWordGen.sv
      - verilog/mipsControl.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/mipsControlTb.sv
